// ==== src.f ====
fetch_pkg.sv
fetch_ctrl_if.sv
instr_mem.sv
if_stage.sv
fetch_ctrl.sv
fetch_top.sv
fetch_props.sv
tb_fetch_top.sv

// ==== tb_fetch_top.sv ====
// Directed testbench for fetch_top; compile with src.f and run tb_fetch_top as top
`timescale 1ns/1ns
`default_nettype none

module tb_fetch_top import fetch_pkg::*; ();

  localparam int  CLK_PERIOD  = 100;
  localparam int  RST_CYCLES  = 8;
  localparam pc_t BOOT_ADDR   = 32'h0000_1040;   // Word index 0x10
  localparam int  N_TESTS     = 5;
  localparam int  LOAD_CYCLES = IMEM_WORDS + RST_CYCLES + 1;  // Per program load
  localparam int  RUN_CYCLES  = 120;             // All stepping, worst case stalls
  localparam int  MARGIN      = 100;
  localparam int  WATCHDOG_NS = (N_TESTS * LOAD_CYCLES + RUN_CYCLES + MARGIN) * CLK_PERIOD;

  logic       clk;
  logic       rst_n;
  pc_t        boot_addr;
  logic       stall;
  logic       irq;
  logic       imem_we;
  imem_addr_t imem_waddr;
  instr_t     imem_wdata;
  instr_t     instr_id;
  pc_t        pc_id;
  logic       id_valid;
  pc_t        epc;

  instr_t      prog [IMEM_WORDS];      // Program image
  int          jal_off [IMEM_WORDS];   // Jump offset of each placed JAL
  logic [31:0] lfsr_q;
  int          n_checks;
  int          n_errors;

  // Reference model state
  logic   m_boot;      // Next edge is the boot edge
  pc_t    m_pc_if;
  pc_t    m_pc_id;
  instr_t m_instr_id;
  logic   m_valid;
  logic   m_pend;      // Interrupt waiting
  pc_t    m_epc;

  fetch_top u_dut
  (
    .clk          (clk),
    .rst_n        (rst_n),
    .boot_addr_i  (boot_addr),
    .stall_i      (stall),
    .irq_i        (irq),
    .imem_we_i    (imem_we),
    .imem_waddr_i (imem_waddr),
    .imem_wdata_i (imem_wdata),
    .instr_id_o   (instr_id),
    .pc_id_o      (pc_id),
    .id_valid_o   (id_valid),
    .epc_o        (epc)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////
  // Helpers
  ////////////////////
  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_q = lfsr_next(lfsr_q);        // One step per bit
      val    = {val[30:0], lfsr_q[0]};
    end
  endtask

  // Legal 32-bit word that is neither JAL nor MRET
  task automatic filler_word(output instr_t w);
    rand_bits(32, w);
    w[1:0] = 2'b11;
    if (w[6:0] == OPCODE_JAL)
      w[3] = ~w[3];
    if (w == INSTR_MRET)
      w[20] = ~w[20];
  endtask

  function automatic imem_addr_t word_idx(input pc_t pc);
    return pc[IMEM_AW+1:2];
  endfunction

  function automatic pc_t irq_vec();
    return {BOOT_ADDR[31:8], EXC_OFF_IRQ};
  endfunction

  function automatic pc_t ill_vec();
    return {BOOT_ADDR[31:8], EXC_OFF_ILLEGAL};
  endfunction

  task automatic fill_memory();
    for (int i = 0; i < IMEM_WORDS; i++)
    begin
      filler_word(prog[i]);
      jal_off[i] = 0;
    end
  endtask

  // JAL x0 with a J-type immediate
  task automatic place_jal(input pc_t pc, input int off);
    logic [31:0] o;
    o = off;
    prog[word_idx(pc)]    = {o[20], o[10:1], o[11], o[19:12], 5'd0, OPCODE_JAL};
    jal_off[word_idx(pc)] = off;
  endtask

  task automatic check_value(input logic [31:0] act, input logic [31:0] exp, input string msg);
    n_checks++;
    if (act !== exp)
    begin
      n_errors++;
      $display("error at %0t ns: %s, got %h, expected %h", $time, msg, act, exp);
    end
  endtask

  // Loads the image under reset, then releases reset on a falling edge
  task automatic start_program();
    @(negedge clk);
    rst_n = 1'b0;
    stall = 1'b0;
    irq   = 1'b0;
    for (int i = 0; i < IMEM_WORDS; i++)
    begin
      imem_we    = 1'b1;
      imem_waddr = imem_addr_t'(i);
      imem_wdata = prog[i];
      @(negedge clk);
    end
    imem_we = 1'b0;
    repeat (RST_CYCLES) @(negedge clk);
    rst_n      = 1'b1;
    m_boot     = 1'b1;
    m_pc_if    = '0;
    m_pc_id    = '0;
    m_instr_id = INSTR_NOP;
    m_valid    = 1'b0;
    m_pend     = 1'b0;
    m_epc      = '0;
  endtask

  ////////////////////
  // Reference model
  ////////////////////
  // Predicts the state after the next rising edge
  task automatic model_edge(input logic stl, input logic irq_in);
    pc_t  target;
    logic squash;
    logic take;
    take   = 1'b0;
    squash = 1'b1;
    if (m_boot)
    begin
      m_pc_if = BOOT_ADDR;   // ID stays empty
      m_valid = 1'b0;
      m_boot  = 1'b0;
    end
    else if (!stl)
    begin
      if (m_pend)
      begin
        target = irq_vec();
        m_epc  = m_pc_if;    // Squashed word resumes later
        take   = 1'b1;
      end
      else if (m_valid && m_instr_id[1:0] != 2'b11)
      begin
        target = ill_vec();
        m_epc  = m_pc_id + 32'd4;
      end
      else if (m_valid && m_instr_id == INSTR_MRET)
        target = m_epc;
      else if (m_valid && m_instr_id[6:0] == OPCODE_JAL)
        target = m_pc_id + jal_off[word_idx(m_pc_id)];
      else
      begin
        target = m_pc_if + 32'd4;
        squash = 1'b0;
      end
      m_instr_id = squash ? INSTR_NOP : prog[word_idx(m_pc_if)];
      m_valid    = ~squash;
      m_pc_id    = m_pc_if;
      m_pc_if    = target;
    end
    m_pend = (m_pend & ~take) | irq_in;   // Strobe seen next edge at the earliest
  endtask

  // Drive on the falling edge, compare one falling edge later
  task automatic step(input logic stall_in, input logic irq_in);
    stall = stall_in;
    irq   = irq_in;
    model_edge(stall_in, irq_in);
    @(posedge clk);
    @(negedge clk);
    check_value(pc_id, m_pc_id, "pc_id_o");
    check_value(instr_id, m_instr_id, "instr_id_o");
    check_value(id_valid, m_valid, "id_valid_o");
    check_value(epc, m_epc, "epc_o");
  endtask

  // 1 to 8 stalled cycles, interrupt strobe in the first one if asked
  task automatic stall_burst(input logic with_irq);
    logic [31:0] len;
    rand_bits(3, len);
    for (int i = 0; i <= int'(len); i++)
      step(1'b1, with_irq && (i == 0));
  endtask

  ////////////////////
  // Tests
  ////////////////////
  task automatic boot_and_sequential();
    fill_memory();
    start_program();
    repeat (2) step(1'b0, 1'b0);
    check_value(pc_id, BOOT_ADDR, "boot address in ID");
    repeat (12) step(1'b0, 1'b0);
  endtask

  task automatic jal_redirects();
    fill_memory();
    place_jal(BOOT_ADDR + 32'h08, 32'h40);    // Forward to BOOT+0x48
    place_jal(BOOT_ADDR + 32'h50, -32'h30);   // Back to BOOT+0x20
    start_program();
    repeat (20) step(1'b0, 1'b0);
  endtask

  task automatic illegal_and_mret();
    fill_memory();
    prog[word_idx(BOOT_ADDR + 32'h0C)][1:0] = 2'b00;   // Compressed-style encoding
    prog[word_idx(ill_vec())]               = INSTR_MRET;
    start_program();
    repeat (8) step(1'b0, 1'b0);
    check_value(epc, BOOT_ADDR + 32'h10, "epc after illegal word");
    repeat (10) step(1'b0, 1'b0);
  endtask

  task automatic interrupt_redirect();
    fill_memory();
    start_program();
    repeat (5) step(1'b0, 1'b0);
    step(1'b0, 1'b1);
    repeat (2) step(1'b0, 1'b0);
    check_value(pc_id, irq_vec(), "interrupt vector in ID");
    check_value(epc, BOOT_ADDR + 32'h14, "epc of squashed word");
    repeat (6) step(1'b0, 1'b0);
  endtask

  task automatic stall_resume();
    fill_memory();
    place_jal(BOOT_ADDR + 32'h10, 32'h20);
    start_program();
    repeat (4) step(1'b0, 1'b0);
    stall_burst(1'b0);                // Sequential code
    repeat (2) step(1'b0, 1'b0);
    check_value(pc_id, BOOT_ADDR + 32'h10, "JAL in ID before stall");
    stall_burst(1'b0);                // JAL held in ID
    repeat (3) step(1'b0, 1'b0);
    stall_burst(1'b1);
    repeat (2) step(1'b0, 1'b0);
    check_value(pc_id, irq_vec(), "interrupt taken after stall");
    repeat (4) step(1'b0, 1'b0);
  endtask

  initial
  begin
    rst_n      = 1'b0;
    boot_addr  = BOOT_ADDR;
    stall      = 1'b0;
    irq        = 1'b0;
    imem_we    = 1'b0;
    imem_waddr = '0;
    imem_wdata = '0;
    lfsr_q     = 32'd72;
    n_checks   = 0;
    n_errors   = 0;
    boot_and_sequential();
    jal_redirects();
    illegal_and_mret();
    interrupt_redirect();
    stall_resume();
    $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

  // Watchdog
  initial
  begin
    #(WATCHDOG_NS);
    $display("Run timed out, tests did not finish within %0d ns", WATCHDOG_NS);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

// ==== fetch_props.sv ====
// Concurrent assertions on the fetch controller, bound into every fetch_ctrl instance
`timescale 1ns/1ns
`default_nettype none

module fetch_props import fetch_pkg::*;
(
  input logic     clk,
  input logic     rst_n,
  input logic     stall_i,
  input logic     running_i,     // Controller left ST_BOOT
  input logic     squash_i,
  input logic     pc_boot_i,
  input pc_sel_e  pc_sel_i,
  input exc_sel_e exc_sel_i,
  input logic     irq_pend_i,
  input pc_t      pc_if_i,       // IF/ID state seen by the controller
  input pc_t      pc_id_i,
  input instr_t   instr_id_i,
  input logic     valid_id_i
);

  ////////////////////
  // Controller rules
  ////////////////////
  // A squash must land as an invalid NOP, which needs an advancing edge
  a_squash_adv: assert property (@(posedge clk) disable iff (!rst_n)
    squash_i |=> (instr_id_i == INSTR_NOP && !valid_id_i))
    else $error("squash did not load a bubble into ID");

  // Boot address is loaded once, right after reset
  a_boot_once: assert property (@(posedge clk) disable iff (!rst_n)
    pc_boot_i == !$past(rst_n))
    else $error("pc_boot outside the first cycle after reset");

  a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (running_i && stall_i) |=>
      ($stable(pc_if_i) && $stable(pc_id_i) && $stable(instr_id_i) && $stable(valid_id_i)))
    else $error("front end moved while stalled");

  a_pend_kept: assert property (@(posedge clk) disable iff (!rst_n)
    (irq_pend_i && !(squash_i && pc_sel_i == PC_EXC && exc_sel_i == EXC_SEL_IRQ))
      |=> irq_pend_i)
    else $error("pending interrupt lost without being taken");

endmodule

bind fetch_ctrl fetch_props u_props
(
  .clk        (clk),
  .rst_n      (rst_n),
  .stall_i    (stall_i),
  .running_i  (running),
  .squash_i   (ctrl.squash),
  .pc_boot_i  (ctrl.pc_boot),
  .pc_sel_i   (ctrl.pc_sel),
  .exc_sel_i  (ctrl.exc_sel),
  .irq_pend_i (irq_pend_q),
  .pc_if_i    (ctrl.pc_if),
  .pc_id_i    (ctrl.pc_id),
  .instr_id_i (ctrl.instr_id),
  .valid_id_i (ctrl.valid_id)
);

`default_nettype wire

// ==== fetch_top.sv ====
// Top level of the fetch front end; ties RAM, IF stage and controller together for the testbench
`timescale 1ns/1ns
`default_nettype none

module fetch_top import fetch_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  pc_t        boot_addr_i,
  input  logic       stall_i,
  input  logic       irq_i,
  input  logic       imem_we_i,      // Program load port
  input  imem_addr_t imem_waddr_i,
  input  instr_t     imem_wdata_i,
  output instr_t     instr_id_o,     // IF/ID contents
  output pc_t        pc_id_o,
  output logic       id_valid_o,
  output pc_t        epc_o
);

  imem_addr_t imem_raddr;
  logic       imem_ren;
  instr_t     imem_rdata;

  fetch_ctrl_if u_ctrl_if ();

  instr_mem u_imem
  (
    .clk       (clk),
    .rd_en_i   (imem_ren),
    .rd_addr_i (imem_raddr),
    .rd_data_o (imem_rdata),
    .wr_en_i   (imem_we_i),
    .wr_addr_i (imem_waddr_i),
    .wr_data_i (imem_wdata_i)
  );

  if_stage u_if_stage
  (
    .clk           (clk),
    .rst_n         (rst_n),
    .boot_addr_i   (boot_addr_i),
    .ctrl          (u_ctrl_if.stage),
    .instr_addr_o  (imem_raddr),
    .instr_req_o   (imem_ren),
    .instr_rdata_i (imem_rdata)
  );

  fetch_ctrl u_fetch_ctrl
  (
    .clk     (clk),
    .rst_n   (rst_n),
    .stall_i (stall_i),
    .irq_i   (irq_i),
    .ctrl    (u_ctrl_if.ctrl),
    .epc_o   (epc_o)
  );

  // ID view for the outside
  assign instr_id_o = u_ctrl_if.instr_id;
  assign pc_id_o    = u_ctrl_if.pc_id;
  assign id_valid_o = u_ctrl_if.valid_id;

endmodule

`default_nettype wire

// ==== fetch_ctrl.sv ====
// Fetch controller: boot sequencing, ID-side redirect decode, pending interrupt and saved EPC
`timescale 1ns/1ns
`default_nettype none

module fetch_ctrl import fetch_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        stall_i,      // Freeze the front end
  input  logic        irq_i,        // Single-cycle interrupt strobe
  fetch_ctrl_if.ctrl  ctrl,
  output pc_t         epc_o         // Saved exception PC
);

  ctrl_state_e state_q, state_d;
  logic        irq_pend_q, irq_pend_d;
  pc_t         epc_q, epc_d;
  logic        running;
  logic        advance;
  logic        irq_take;
  logic        id_jal;
  logic        id_mret;
  logic        id_illegal;
  pc_t         j_imm;

  ////////////////////
  // Boot FSM
  ////////////////////
  always_comb
  begin
    state_d = state_q;
    case (state_q)
      ST_BOOT: state_d = ST_RUN;    // One boot cycle only
      ST_RUN:  state_d = ST_RUN;
      default: state_d = ST_BOOT;
    endcase
  end

  assign running = (state_q == ST_RUN);

  // Boot cycle ignores the stall
  assign advance = ~running | ~stall_i;

  ////////////////////
  // ID decode
  ////////////////////
  // Bubbles never redirect
  assign id_jal     = ctrl.valid_id && (ctrl.instr_id[6:0] == OPCODE_JAL);
  assign id_mret    = ctrl.valid_id && (ctrl.instr_id == INSTR_MRET);
  assign id_illegal = ctrl.valid_id && (ctrl.instr_id[1:0] != 2'b11);   // Not a 32-bit encoding

  // J-type immediate, bit 0 always zero
  assign j_imm = {{12{ctrl.instr_id[31]}}, ctrl.instr_id[19:12], ctrl.instr_id[20],
                  ctrl.instr_id[30:21], 1'b0};

  assign irq_take = running && advance && irq_pend_q;

  ////////////////////
  // Redirect priority
  ////////////////////
  always_comb
  begin
    ctrl.pc_sel  = PC_INCR;
    ctrl.exc_sel = EXC_SEL_ILLEGAL;
    ctrl.squash  = 1'b0;
    epc_d        = epc_q;
    if (!running)
    begin
      ctrl.pc_sel = PC_INCR;          // Boot address comes via pc_boot
    end
    else if (!advance)
    begin
      ctrl.pc_sel = PC_HOLD;          // Stalled, decisions wait
    end
    else if (irq_take)
    begin
      ctrl.pc_sel  = PC_EXC;
      ctrl.exc_sel = EXC_SEL_IRQ;
      ctrl.squash  = 1'b1;
      epc_d        = ctrl.pc_if;      // Resume at the squashed word
    end
    else if (id_illegal)
    begin
      ctrl.pc_sel  = PC_EXC;
      ctrl.exc_sel = EXC_SEL_ILLEGAL;
      ctrl.squash  = 1'b1;
      epc_d        = ctrl.pc_id + 32'd4;   // Skip the bad word
    end
    else if (id_mret)
    begin
      ctrl.pc_sel = PC_EPC;
      ctrl.squash = 1'b1;
    end
    else if (id_jal)
    begin
      ctrl.pc_sel = PC_JAL_IMM;
      ctrl.squash = 1'b1;
    end
  end

  // Strobe is caught even while stalled, cleared only when taken
  assign irq_pend_d = (irq_pend_q & ~irq_take) | irq_i;

  ////////////////////
  // State registers
  ////////////////////
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q    <= ST_BOOT;
      irq_pend_q <= 1'b0;
      epc_q      <= '0;
    end
    else
    begin
      state_q    <= state_d;
      irq_pend_q <= irq_pend_d;
      if (advance)
        epc_q <= epc_d;
    end
  end

  assign ctrl.pc_jal_imm = j_imm;
  assign ctrl.epc        = epc_q;
  assign ctrl.pc_boot    = ~running;
  assign ctrl.drop       = ~running;    // ID stays empty during boot
  assign ctrl.advance    = advance;
  assign epc_o           = epc_q;

endmodule

`default_nettype wire

// ==== if_stage.sv ====
// IF stage: next-PC and vector muxes, IF PC register and IF/ID pipeline register
`timescale 1ns/1ns
`default_nettype none

module if_stage import fetch_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  pc_t          boot_addr_i,     // Also the base of the vectors
  fetch_ctrl_if.stage  ctrl,
  output imem_addr_t   instr_addr_o,    // Word index to the RAM
  output logic         instr_req_o,     // RAM read enable
  input  instr_t       instr_rdata_i    // Word at pc_if, one cycle late
);

  pc_t    next_pc;      // Mux output
  pc_t    exc_pc;       // Selected vector
  pc_t    fetch_pc;     // Address actually fetched
  pc_t    pc_if_q;
  pc_t    pc_id_q;
  instr_t instr_id_q;
  logic   valid_id_q;
  instr_t instr_if;     // Word going into IF/ID

  ////////////////////
  // Vector mux
  ////////////////////
  always_comb
  begin
    case (ctrl.exc_sel)
      EXC_SEL_IRQ:     exc_pc = {boot_addr_i[31:8], EXC_OFF_IRQ};
      EXC_SEL_ILLEGAL: exc_pc = {boot_addr_i[31:8], EXC_OFF_ILLEGAL};
      default:         exc_pc = {boot_addr_i[31:8], EXC_OFF_ILLEGAL};
    endcase
  end

  ////////////////////
  // Next-PC mux
  ////////////////////
  always_comb
  begin
    case (ctrl.pc_sel)
      PC_INCR:    next_pc = pc_if_q + 32'd4;              // Sequential
      PC_HOLD:    next_pc = pc_if_q;                      // Stall
      PC_JAL_IMM: next_pc = pc_id_q + ctrl.pc_jal_imm;    // Jump relative to ID
      PC_EXC:     next_pc = exc_pc;
      PC_EPC:     next_pc = ctrl.epc;                     // Return from trap
      default:    next_pc = pc_if_q + 32'd4;
    endcase
  end

  // Boot address wins in the first cycle
  assign fetch_pc = ctrl.pc_boot ? boot_addr_i : next_pc;

  // Same address goes to the RAM and the PC register, so data lines up with pc_if
  assign instr_addr_o = fetch_pc[IMEM_AW+1:2];
  assign instr_req_o  = ctrl.advance;

  ////////////////////
  // IF PC register
  ////////////////////
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      pc_if_q <= '0;
    else if (ctrl.advance)
      pc_if_q <= fetch_pc;
  end

  // Wrong-path word becomes a bubble
  assign instr_if = ctrl.squash ? INSTR_NOP : instr_rdata_i;

  ////////////////////
  // IF/ID register
  ////////////////////
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      instr_id_q <= INSTR_NOP;
      pc_id_q    <= '0;
      valid_id_q <= 1'b0;
    end
    else if (ctrl.drop)
    begin
      valid_id_q <= 1'b0;          // Nothing fetched yet
    end
    else if (ctrl.advance)
    begin
      instr_id_q <= instr_if;
      pc_id_q    <= pc_if_q;
      valid_id_q <= ~ctrl.squash;  // Bubble is invalid
    end
  end

  assign ctrl.pc_if    = pc_if_q;
  assign ctrl.pc_id    = pc_id_q;
  assign ctrl.instr_id = instr_id_q;
  assign ctrl.valid_id = valid_id_q;

endmodule

`default_nettype wire

// ==== instr_mem.sv ====
// Word-wide instruction RAM; registered read for the IF stage, write port for program loading
`timescale 1ns/1ns
`default_nettype none

module instr_mem import fetch_pkg::*;
(
  input  logic       clk,
  input  logic       rd_en_i,     // Read strobe, output holds while low
  input  imem_addr_t rd_addr_i,
  output instr_t     rd_data_o,   // Valid one cycle after rd_en_i
  input  logic       wr_en_i,     // Loader write
  input  imem_addr_t wr_addr_i,
  input  instr_t     wr_data_i
);

  instr_t mem_q [IMEM_WORDS];   // Storage, survives reset

  ////////////////////
  // Write port
  ////////////////////
  always_ff @(posedge clk)
  begin
    if (wr_en_i)
      mem_q[wr_addr_i] <= wr_data_i;
  end

  ////////////////////
  // Read port
  ////////////////////
  always_ff @(posedge clk)
  begin
    if (rd_en_i)
      rd_data_o <= mem_q[rd_addr_i];  // Frozen on stall
  end

endmodule

`default_nettype wire

// ==== fetch_ctrl_if.sv ====
// Control bundle from the fetch controller to the IF stage and the IF/ID state fed back to it
`timescale 1ns/1ns
`default_nettype none

interface fetch_ctrl_if import fetch_pkg::*; ();

  // Controller to IF stage
  pc_sel_e  pc_sel;       // Next-PC source
  exc_sel_e exc_sel;      // Which vector for PC_EXC
  pc_t      pc_jal_imm;   // Sign-extended J-immediate
  pc_t      epc;          // Return target for MRET
  logic     pc_boot;      // Load the boot address
  logic     advance;      // Front end moves this cycle
  logic     squash;       // Turn the IF word into a NOP bubble
  logic     drop;         // Clear ID valid, load nothing

  // IF stage back to the controller
  pc_t      pc_if;
  pc_t      pc_id;
  instr_t   instr_id;
  logic     valid_id;

  modport ctrl  (output pc_sel, exc_sel, pc_jal_imm, epc, pc_boot, advance, squash, drop,
                 input  pc_if, pc_id, instr_id, valid_id);

  modport stage (input  pc_sel, exc_sel, pc_jal_imm, epc, pc_boot, advance, squash, drop,
                 output pc_if, pc_id, instr_id, valid_id);

endinterface

`default_nettype wire

// ==== fetch_pkg.sv ====
// Shared types, encodings and constants for the fetch front end; imported by every design file
`default_nettype none

package fetch_pkg;

  ////////////////////
  // Widths
  ////////////////////
  typedef logic [31:0] pc_t;      // Byte address
  typedef logic [31:0] instr_t;   // Raw instruction word

  localparam int unsigned IMEM_WORDS = 256;   // Instruction RAM depth in words
  localparam int unsigned IMEM_AW    = 8;     // Word index is PC[9:2]

  typedef logic [IMEM_AW-1:0] imem_addr_t;

  ////////////////////
  // Control encodings
  ////////////////////
  typedef enum logic [2:0] {
    PC_INCR    = 3'd0,    // IF PC plus 4
    PC_HOLD    = 3'd1,    // IF PC unchanged
    PC_JAL_IMM = 3'd2,    // ID PC plus J-immediate
    PC_EXC     = 3'd3,    // Exception vector
    PC_EPC     = 3'd4     // Saved exception PC
  } pc_sel_e;

  typedef enum logic [1:0] {
    EXC_SEL_IRQ     = 2'd0,
    EXC_SEL_ILLEGAL = 2'd1
  } exc_sel_e;

  typedef enum logic [1:0] {
    ST_BOOT = 2'd0,       // First cycle out of reset
    ST_RUN  = 2'd1
  } ctrl_state_e;

  // Vector offsets, appended to boot_addr[31:8]
  localparam logic [7:0] EXC_OFF_IRQ     = 8'h00;
  localparam logic [7:0] EXC_OFF_ILLEGAL = 8'h84;

  ////////////////////
  // Instruction constants
  ////////////////////
  localparam instr_t     INSTR_NOP  = 32'h0000_0013;  // addi x0, x0, 0
  localparam logic [6:0] OPCODE_JAL = 7'b110_1111;
  localparam instr_t     INSTR_MRET = 32'h3020_0073;

endpackage

`default_nettype wire
